//--- verilog/operand_pkg.sv
`default_nettype none

package operand_pkg;

  localparam int reg_num_w = 4;
  localparam logic [reg_num_w-1:0] reg_ip = 4'd15;

  // register number fields of the command word
  localparam int fld_s1_lsb  = 0;
  localparam int fld_s0_lsb  = 4;
  localparam int fld_d_lsb   = 8;
  localparam int fld_cnd_lsb = 12;

  // pointer bits 16..19 and flag pairs 21:20..27:26, ordered s1, s0, d, cond
  localparam int fld_ptr_lsb   = 16;
  localparam int fld_flags_lsb = 20;

  typedef enum logic [1:0] {
    upd_none = 2'b00,
    upd_inc  = 2'b01,
    upd_dec  = 2'b10,
    upd_skip = 2'b11
  } upd_t;

  typedef enum logic [1:0] {sel_cond, sel_src1, sel_src0} opnd_sel_t;

  typedef enum logic [2:0] {ph_idle, ph_fetch, ph_present, ph_wb, ph_done} phase_t;

  function automatic logic [reg_num_w-1:0] reg_of(input logic [31:0] cmd, input opnd_sel_t sel);
    case (sel)
      sel_src1: reg_of = cmd[fld_s1_lsb +: reg_num_w];
      sel_src0: reg_of = cmd[fld_s0_lsb +: reg_num_w];
      default:  reg_of = cmd[fld_cnd_lsb +: reg_num_w];
    endcase
  endfunction

  function automatic logic ptr_of(input logic [31:0] cmd, input opnd_sel_t sel);
    case (sel)
      sel_src1: ptr_of = cmd[fld_ptr_lsb];
      sel_src0: ptr_of = cmd[fld_ptr_lsb + 1];
      default:  ptr_of = cmd[fld_ptr_lsb + 3];
    endcase
  endfunction

  function automatic upd_t upd_of(input logic [31:0] cmd, input opnd_sel_t sel);
    case (sel)
      sel_src1: upd_of = upd_t'(cmd[fld_flags_lsb +: 2]);
      sel_src0: upd_of = upd_t'(cmd[fld_flags_lsb + 2 +: 2]);
      default:  upd_of = upd_t'(cmd[fld_flags_lsb + 6 +: 2]);
    endcase
  endfunction

endpackage

`default_nettype wire

//--- verilog/axi_lite_master.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_master #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                mem_req,
  input  logic                mem_we,
  input  logic [ADDR_W-1:0]   mem_addr,
  input  logic [DATA_W-1:0]   mem_wdata,
  output logic                mem_ack,
  output logic [DATA_W-1:0]   mem_rdata,
  output logic                awvalid,
  input  logic                awready,
  output logic [ADDR_W-1:0]   awaddr,
  output logic                wvalid,
  input  logic                wready,
  output logic [DATA_W-1:0]   wdata,
  output logic [DATA_W/8-1:0] wstrb,
  input  logic                bvalid,
  output logic                bready,
  output logic                arvalid,
  input  logic                arready,
  output logic [ADDR_W-1:0]   araddr,
  input  logic                rvalid,
  output logic                rready,
  input  logic [DATA_W-1:0]   rdata
);

  typedef enum logic [1:0] {st_idle, st_wr, st_rd, st_ack} state_t;

  state_t            state;
  logic [ADDR_W-1:0] addr_q;

  // one address register serves both channels
  assign awaddr  = addr_q;
  assign araddr  = addr_q;
  assign wstrb   = '1;
  // response accepted only once both write channels are through
  assign bready  = state == st_wr && !awvalid && !wvalid;
  assign rready  = state == st_rd && !arvalid;
  assign mem_ack = state == st_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= st_idle;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      arvalid <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (mem_req && mem_we) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            state   <= st_wr;
          end else if (mem_req) begin
            arvalid <= 1'b1;
            state   <= st_rd;
          end
        end
        st_wr: begin
          if (awready) begin
            awvalid <= 1'b0;
          end
          if (wready) begin
            wvalid <= 1'b0;
          end
          if (bvalid && bready) begin
            state <= st_ack;
          end
        end
        st_rd: begin
          if (arready) begin
            arvalid <= 1'b0;
          end
          if (rvalid && rready) begin
            state <= st_ack;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && mem_req) begin
      addr_q <= mem_addr;
      wdata  <= mem_wdata;
    end
    if (rvalid && rready) begin
      mem_rdata <= rdata;
    end
  end

  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid && !awready |=> awvalid && $stable(awaddr));
  a_w_hold: assert property (@(posedge clk) disable iff (rst)
    wvalid && !wready |=> wvalid && $stable(wdata));
  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid && !arready |=> arvalid && $stable(araddr));

endmodule

`default_nettype wire

//--- verilog/operand_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module operand_fetch #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              fetch_start,
  input  logic [31:0]       cmd_word,
  input  logic [ADDR_W-1:0] base_addr,
  input  logic [DATA_W-1:0] ip_value,
  output logic              mem_req,
  output logic              mem_we,
  output logic [ADDR_W-1:0] mem_addr,
  output logic [DATA_W-1:0] mem_wdata,
  input  logic              mem_ack,
  input  logic [DATA_W-1:0] mem_rdata,
  output logic              fetch_done,
  output logic [DATA_W-1:0] cond_val,
  output logic [DATA_W-1:0] src1_val,
  output logic [DATA_W-1:0] src0_val,
  output logic [DATA_W-1:0] cond_ptr,
  output logic [DATA_W-1:0] src1_ptr,
  output logic [DATA_W-1:0] src0_ptr
);

  typedef enum logic [1:0] {st_idle, st_slot, st_ptr} step_t;

  step_t                             step;
  operand_pkg::opnd_sel_t            sel;
  logic [DATA_W-1:0]                 val_q [3];
  logic [DATA_W-1:0]                 ptr_q [3];
  logic [operand_pkg::reg_num_w-1:0] reg_n;
  logic                              is_ptr;
  logic                              is_ip;
  logic                              slot_got;
  logic                              op_done;
  logic [DATA_W-1:0]                 slot_val;

  assign reg_n  = operand_pkg::reg_of(cmd_word, sel);
  assign is_ptr = operand_pkg::ptr_of(cmd_word, sel);
  // the ip register is never read from memory
  assign is_ip  = reg_n == operand_pkg::reg_ip;

  assign slot_got = step == st_slot && (is_ip || mem_ack);
  assign slot_val = is_ip ? ip_value : mem_rdata;
  assign op_done  = (slot_got && !is_ptr) || (step == st_ptr && mem_ack);

  assign mem_req   = (step == st_slot && !is_ip) || step == st_ptr;
  assign mem_we    = 1'b0;
  assign mem_wdata = '0;
  // pointer value is used as a byte address
  assign mem_addr  = step == st_ptr ? ADDR_W'(ptr_q[sel])
                                    : base_addr + ADDR_W'({reg_n, 2'b00});

  always_ff @(posedge clk) begin
    fetch_done <= 1'b0;
    if (rst) begin
      step <= st_idle;
      sel  <= operand_pkg::sel_cond;
    end else if (step == st_idle) begin
      if (fetch_start) begin
        sel  <= operand_pkg::sel_cond;
        step <= st_slot;
      end
    end else if (op_done) begin
      if (sel == operand_pkg::sel_src0) begin
        step       <= st_idle;
        fetch_done <= 1'b1;
      end else begin
        sel  <= operand_pkg::opnd_sel_t'(sel + 2'd1);
        step <= st_slot;
      end
    end else if (slot_got) begin
      step <= st_ptr;
    end
  end

  always_ff @(posedge clk) begin
    if (slot_got) begin
      val_q[sel] <= slot_val;
      ptr_q[sel] <= slot_val;
    end else if (step == st_ptr && mem_ack) begin
      val_q[sel] <= mem_rdata;
    end
  end

  assign cond_val = val_q[operand_pkg::sel_cond];
  assign src1_val = val_q[operand_pkg::sel_src1];
  assign src0_val = val_q[operand_pkg::sel_src0];
  assign cond_ptr = ptr_q[operand_pkg::sel_cond];
  assign src1_ptr = ptr_q[operand_pkg::sel_src1];
  assign src0_ptr = ptr_q[operand_pkg::sel_src0];

  // read only, and the request is held until its ack
  a_read_hold: assert property (@(posedge clk) disable iff (rst)
    mem_req && !mem_ack |=> mem_req && !mem_we && $stable(mem_addr));

endmodule

`default_nettype wire

//--- verilog/operand_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module operand_writeback #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              wb_start,
  input  logic [31:0]       cmd_word,
  input  logic [ADDR_W-1:0] base_addr,
  input  logic [DATA_W-1:0] res_data,
  input  logic [DATA_W-1:0] cond_val,
  input  logic [DATA_W-1:0] src1_val,
  input  logic [DATA_W-1:0] src0_val,
  input  logic [DATA_W-1:0] cond_ptr,
  input  logic [DATA_W-1:0] src1_ptr,
  input  logic [DATA_W-1:0] src0_ptr,
  output logic              mem_req,
  output logic              mem_we,
  output logic [ADDR_W-1:0] mem_addr,
  output logic [DATA_W-1:0] mem_wdata,
  input  logic              mem_ack,
  output logic              wb_done
);

  typedef enum logic [1:0] {st_idle, st_dst, st_src} step_t;

  step_t                             step;
  operand_pkg::opnd_sel_t            sel;
  logic [DATA_W-1:0]                 res_q;
  logic [operand_pkg::reg_num_w-1:0] dst_reg;
  logic [operand_pkg::reg_num_w-1:0] src_reg;
  operand_pkg::upd_t                 dst_upd;
  operand_pkg::upd_t                 src_upd;
  logic                              dst_wr;
  logic                              src_wr;
  logic                              src_ptr;
  logic                              step_done;
  logic [DATA_W-1:0]                 dst_val;
  logic [DATA_W-1:0]                 val_sel;
  logic [DATA_W-1:0]                 ptr_sel;
  logic [DATA_W-1:0]                 src_old;
  logic [ADDR_W-1:0]                 ip_addr;

  function automatic logic [DATA_W-1:0] bump(input logic [DATA_W-1:0] v,
                                             input operand_pkg::upd_t u);
    case (u)
      operand_pkg::upd_inc: bump = v + DATA_W'(1);
      operand_pkg::upd_dec: bump = v - DATA_W'(1);
      default:              bump = v;
    endcase
  endfunction

  assign dst_reg = cmd_word[operand_pkg::fld_d_lsb +: operand_pkg::reg_num_w];
  assign dst_upd = operand_pkg::upd_t'(cmd_word[operand_pkg::fld_flags_lsb + 4 +: 2]);
  assign dst_wr  = dst_upd != operand_pkg::upd_skip && dst_reg != operand_pkg::reg_ip;
  assign dst_val = bump(res_q, dst_upd);

  assign src_reg = operand_pkg::reg_of(cmd_word, sel);
  assign src_upd = operand_pkg::upd_of(cmd_word, sel);
  assign src_ptr = operand_pkg::ptr_of(cmd_word, sel);
  assign src_wr  = (src_upd == operand_pkg::upd_inc || src_upd == operand_pkg::upd_dec) &&
                   src_reg != operand_pkg::reg_ip;

  always_comb begin
    case (sel)
      operand_pkg::sel_src1: begin
        val_sel = src1_val;
        ptr_sel = src1_ptr;
      end
      operand_pkg::sel_src0: begin
        val_sel = src0_val;
        ptr_sel = src0_ptr;
      end
      default: begin
        val_sel = cond_val;
        ptr_sel = cond_ptr;
      end
    endcase
  end

  // a direct operand naming the written destination starts from the new value
  assign src_old = src_ptr ? ptr_sel :
                   (dst_wr && src_reg == dst_reg) ? dst_val : val_sel;

  assign mem_req   = (step == st_dst && dst_wr) || (step == st_src && src_wr);
  assign mem_we    = 1'b1;
  assign mem_addr  = base_addr + ADDR_W'({(step == st_dst ? dst_reg : src_reg), 2'b00});
  assign mem_wdata = step == st_dst ? dst_val : bump(src_old, src_upd);
  assign ip_addr   = base_addr + ADDR_W'({operand_pkg::reg_ip, 2'b00});

  // steps without a write pass in one cycle
  assign step_done = step != st_idle && (!mem_req || mem_ack);

  always_ff @(posedge clk) begin
    wb_done <= 1'b0;
    if (rst) begin
      step <= st_idle;
      sel  <= operand_pkg::sel_cond;
    end else if (step == st_idle) begin
      if (wb_start) begin
        step <= st_dst;
      end
    end else if (step_done) begin
      if (step == st_dst) begin
        step <= st_src;
        sel  <= operand_pkg::sel_cond;
      end else if (sel == operand_pkg::sel_src0) begin
        step    <= st_idle;
        wb_done <= 1'b1;
      end else begin
        sel <= operand_pkg::opnd_sel_t'(sel + 2'd1);
      end
    end
  end

  // result follows the input while idle and freezes from the accept cycle on
  always_ff @(posedge clk) begin
    if (step == st_idle && !wb_start) begin
      res_q <= res_data;
    end
  end

  a_no_ip_write: assert property (@(posedge clk) disable iff (rst)
    mem_req |-> mem_addr != ip_addr);

endmodule

`default_nettype wire

//--- verilog/operand_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module operand_sequencer #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              cmd_valid,
  input  logic [31:0]       cmd_word,
  input  logic [ADDR_W-1:0] base_addr,
  input  logic [DATA_W-1:0] ip_value,
  output logic              cmd_ready,
  input  logic              res_valid,
  output logic              res_ready,
  output logic              opnd_valid,
  output logic              done,
  output logic              fetch_start,
  output logic              wb_start,
  input  logic              fetch_done,
  input  logic              wb_done,
  output logic [31:0]       cmd_q,
  output logic [ADDR_W-1:0] base_q,
  output logic [DATA_W-1:0] ip_q,
  input  logic              fetch_mem_req,
  input  logic              fetch_mem_we,
  input  logic [ADDR_W-1:0] fetch_mem_addr,
  input  logic [DATA_W-1:0] fetch_mem_wdata,
  output logic              fetch_mem_ack,
  output logic [DATA_W-1:0] fetch_mem_rdata,
  input  logic              wb_mem_req,
  input  logic              wb_mem_we,
  input  logic [ADDR_W-1:0] wb_mem_addr,
  input  logic [DATA_W-1:0] wb_mem_wdata,
  output logic              wb_mem_ack,
  output logic              mem_req,
  output logic              mem_we,
  output logic [ADDR_W-1:0] mem_addr,
  output logic [DATA_W-1:0] mem_wdata,
  input  logic              mem_ack,
  input  logic [DATA_W-1:0] mem_rdata
);

  operand_pkg::phase_t phase;
  operand_pkg::phase_t phase_n;
  logic                accept;
  logic                wb_sel;

  assign accept = cmd_valid && cmd_ready;

  always_comb begin
    phase_n = phase;
    case (phase)
      operand_pkg::ph_idle:    if (accept) phase_n = operand_pkg::ph_fetch;
      operand_pkg::ph_fetch:   if (fetch_done) phase_n = operand_pkg::ph_present;
      operand_pkg::ph_present: if (res_valid) phase_n = operand_pkg::ph_wb;
      operand_pkg::ph_wb:      if (wb_done) phase_n = operand_pkg::ph_done;
      default:                 phase_n = operand_pkg::ph_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phase       <= operand_pkg::ph_idle;
      cmd_ready   <= 1'b0;
      fetch_start <= 1'b0;
      wb_start    <= 1'b0;
    end else begin
      phase       <= phase_n;
      cmd_ready   <= phase_n == operand_pkg::ph_idle;
      fetch_start <= accept;
      wb_start    <= res_valid && res_ready;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q  <= cmd_word;
      base_q <= base_addr;
      ip_q   <= ip_value;
    end
  end

  assign opnd_valid = phase == operand_pkg::ph_present;
  assign res_ready  = phase == operand_pkg::ph_present;
  assign done       = phase == operand_pkg::ph_done;

  // writeback owns the memory port only in its phase
  assign wb_sel          = phase == operand_pkg::ph_wb;
  assign mem_req         = wb_sel ? wb_mem_req : fetch_mem_req;
  assign mem_we          = wb_sel ? wb_mem_we : fetch_mem_we;
  assign mem_addr        = wb_sel ? wb_mem_addr : fetch_mem_addr;
  assign mem_wdata       = wb_sel ? wb_mem_wdata : fetch_mem_wdata;
  assign fetch_mem_ack   = mem_ack && !wb_sel;
  assign wb_mem_ack      = mem_ack && wb_sel;
  assign fetch_mem_rdata = mem_rdata;

  a_fetch_phase: assert property (@(posedge clk) disable iff (rst)
    fetch_mem_req |-> phase == operand_pkg::ph_fetch);
  a_wb_phase: assert property (@(posedge clk) disable iff (rst)
    wb_mem_req |-> phase == operand_pkg::ph_wb);

endmodule

`default_nettype wire

//--- verilog/operand_unit.sv
`timescale 1ns/1ps
`default_nettype none

module operand_unit #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                cmd_valid,
  output logic                cmd_ready,
  input  logic [31:0]         cmd_word,
  input  logic [ADDR_W-1:0]   base_addr,
  input  logic [DATA_W-1:0]   ip_value,
  output logic                opnd_valid,
  output logic [DATA_W-1:0]   cond_val,
  output logic [DATA_W-1:0]   src1_val,
  output logic [DATA_W-1:0]   src0_val,
  input  logic                res_valid,
  output logic                res_ready,
  input  logic [DATA_W-1:0]   res_data,
  output logic                done,
  output logic                awvalid,
  input  logic                awready,
  output logic [ADDR_W-1:0]   awaddr,
  output logic                wvalid,
  input  logic                wready,
  output logic [DATA_W-1:0]   wdata,
  output logic [DATA_W/8-1:0] wstrb,
  input  logic                bvalid,
  output logic                bready,
  output logic                arvalid,
  input  logic                arready,
  output logic [ADDR_W-1:0]   araddr,
  input  logic                rvalid,
  output logic                rready,
  input  logic [DATA_W-1:0]   rdata
);

  logic              fetch_start, fetch_done, wb_start, wb_done;
  logic [31:0]       cmd_q;
  logic [ADDR_W-1:0] base_q;
  logic [DATA_W-1:0] ip_q;
  logic [DATA_W-1:0] cond_ptr, src1_ptr, src0_ptr;

  // client ports and the shared master port
  logic              f_req, f_we, f_ack, w_req, w_we, w_ack, m_req, m_we, m_ack;
  logic [ADDR_W-1:0] f_addr, w_addr, m_addr;
  logic [DATA_W-1:0] f_wdata, f_rdata, w_wdata, m_wdata, m_rdata;

  operand_sequencer #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) seq_i (
    .clk, .rst, .cmd_valid, .cmd_word, .base_addr, .ip_value, .cmd_ready,
    .res_valid, .res_ready, .opnd_valid, .done,
    .fetch_start, .wb_start, .fetch_done, .wb_done, .cmd_q, .base_q, .ip_q,
    .fetch_mem_req(f_req), .fetch_mem_we(f_we), .fetch_mem_addr(f_addr),
    .fetch_mem_wdata(f_wdata), .fetch_mem_ack(f_ack), .fetch_mem_rdata(f_rdata),
    .wb_mem_req(w_req), .wb_mem_we(w_we), .wb_mem_addr(w_addr),
    .wb_mem_wdata(w_wdata), .wb_mem_ack(w_ack),
    .mem_req(m_req), .mem_we(m_we), .mem_addr(m_addr), .mem_wdata(m_wdata),
    .mem_ack(m_ack), .mem_rdata(m_rdata)
  );

  operand_fetch #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) fetch_i (
    .clk, .rst, .fetch_start, .cmd_word(cmd_q), .base_addr(base_q), .ip_value(ip_q),
    .mem_req(f_req), .mem_we(f_we), .mem_addr(f_addr), .mem_wdata(f_wdata),
    .mem_ack(f_ack), .mem_rdata(f_rdata), .fetch_done,
    .cond_val, .src1_val, .src0_val, .cond_ptr, .src1_ptr, .src0_ptr
  );

  operand_writeback #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) wb_i (
    .clk, .rst, .wb_start, .cmd_word(cmd_q), .base_addr(base_q), .res_data,
    .cond_val, .src1_val, .src0_val, .cond_ptr, .src1_ptr, .src0_ptr,
    .mem_req(w_req), .mem_we(w_we), .mem_addr(w_addr), .mem_wdata(w_wdata),
    .mem_ack(w_ack), .wb_done
  );

  axi_lite_master #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) axi_i (
    .clk, .rst,
    .mem_req(m_req), .mem_we(m_we), .mem_addr(m_addr), .mem_wdata(m_wdata),
    .mem_ack(m_ack), .mem_rdata(m_rdata),
    .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
    .bvalid, .bready, .arvalid, .arready, .araddr, .rvalid, .rready, .rdata
  );

endmodule

`default_nettype wire

//--- dv/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model #(
  parameter int          WORDS = 256,
  parameter logic [15:0] SEED  = 16'd58
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] awaddr,
  input  logic        wvalid,
  output logic        wready,
  input  logic [31:0] wdata,
  output logic        bvalid,
  input  logic        bready,
  input  logic        arvalid,
  output logic        arready,
  input  logic [31:0] araddr,
  output logic        rvalid,
  input  logic        rready,
  output logic [31:0] rdata,
  output logic        log_valid,
  output logic [31:0] log_addr,
  output logic [31:0] log_data
);

  localparam int IDX_W = $clog2(WORDS);

  logic [31:0] mem [WORDS];
  logic [15:0] rnd_q;
  logic [15:0] rnd_n;
  logic [1:0]  aw_wait;
  logic [1:0]  w_wait;
  logic [1:0]  ar_wait;
  logic        aw_got;
  logic        w_got;
  logic [31:0] aw_addr_q;
  logic [31:0] w_data_q;

  // fibonacci lfsr, taps 16 14 13 11, one step per bit
  function automatic logic [15:0] lfsr_advance(input logic [15:0] s, input int n);
    int i;
    for (i = 0; i < n; i++) begin
      s = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    end
    return s;
  endfunction

  // every word points back into the array
  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = 32'(((i * 29 + 17) % WORDS) * 4);
    end
  end

  // four fresh bits per cycle, aw and ar take the low pair, w the high pair
  assign rnd_n   = lfsr_advance(rnd_q, 4);
  assign awready = aw_wait == 2'd0 && !aw_got;
  assign wready  = w_wait == 2'd0 && !w_got;
  assign arready = ar_wait == 2'd0 && !rvalid;

  always @(posedge clk) begin
    log_valid <= 1'b0;
    if (rst) begin
      rnd_q   <= SEED;
      aw_wait <= 2'd0;
      w_wait  <= 2'd0;
      ar_wait <= 2'd0;
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
      bvalid  <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      rnd_q <= rnd_n;
      if (awvalid && awready) begin
        aw_got    <= 1'b1;
        aw_addr_q <= awaddr;
        aw_wait   <= rnd_n[1:0];
      end else if (awvalid && aw_wait != 2'd0) begin
        aw_wait <= aw_wait - 2'd1;
      end
      if (wvalid && wready) begin
        w_got    <= 1'b1;
        w_data_q <= wdata;
        w_wait   <= rnd_n[3:2];
      end else if (wvalid && w_wait != 2'd0) begin
        w_wait <= w_wait - 2'd1;
      end
      // commit once both halves of the write are in
      if (aw_got && w_got && !bvalid) begin
        mem[aw_addr_q[2 +: IDX_W]] <= w_data_q;
        log_valid <= 1'b1;
        log_addr  <= aw_addr_q;
        log_data  <= w_data_q;
        bvalid    <= 1'b1;
        aw_got    <= 1'b0;
        w_got     <= 1'b0;
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (arvalid && arready) begin
        rvalid  <= 1'b1;
        rdata   <= mem[araddr[2 +: IDX_W]];
        ar_wait <= rnd_n[1:0];
      end else if (arvalid && ar_wait != 2'd0) begin
        ar_wait <= ar_wait - 2'd1;
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- dv/tb_operand_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_operand_unit;

  localparam int WORDS    = 256;
  localparam int IDX_W    = $clog2(WORDS);
  localparam int NUM_CMDS = 80;

  logic        clk = 1'b0;
  logic        rst;
  logic        cmd_valid, cmd_ready, opnd_valid, res_valid, res_ready, done;
  logic [31:0] cmd_word, base_addr, ip_value, res_data;
  logic [31:0] cond_val, src1_val, src0_val;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready;
  logic [31:0] awaddr, wdata, araddr, rdata;
  logic [3:0]  wstrb;
  logic        log_valid;
  logic [31:0] log_addr, log_data;

  // reference state
  logic [15:0] lfsr_q = 16'd58;
  logic [31:0] shadow [WORDS];
  logic [31:0] exp_opnd [3];
  logic [31:0] exp_addr_q [$];
  logic [31:0] exp_data_q [$];
  logic [31:0] cur_base;
  logic        busy;
  int          done_count;

  operand_unit #(.ADDR_W(32), .DATA_W(32)) dut_i (.*);

  axi_mem_model #(.WORDS(WORDS), .SEED(16'd58)) mem_i (.*);

  always #4 clk = ~clk;

  task automatic flag_mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "wrong value");
  endtask

  task automatic abort_run(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "run aborted");
  endtask

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // operand k: 0 cond, 1 src1, 2 src0
  function automatic logic [3:0] reg_field(input logic [31:0] cmd, input int k);
    case (k)
      0: return cmd[15:12];
      1: return cmd[3:0];
      default: return cmd[7:4];
    endcase
  endfunction

  function automatic logic ptr_field(input logic [31:0] cmd, input int k);
    case (k)
      0: return cmd[19];
      1: return cmd[16];
      default: return cmd[17];
    endcase
  endfunction

  function automatic logic [1:0] flag_field(input logic [31:0] cmd, input int k);
    case (k)
      0: return cmd[27:26];
      1: return cmd[21:20];
      default: return cmd[23:22];
    endcase
  endfunction

  task automatic expect_write(input logic [31:0] addr, input logic [31:0] data);
    exp_addr_q.push_back(addr);
    exp_data_q.push_back(data);
    shadow[addr[2 +: IDX_W]] = data;
  endtask

  // expected operands and ordered write list for one command
  task automatic predict_command(input logic [31:0] cmd, input logic [31:0] base,
                                 input logic [31:0] ip, input logic [31:0] res);
    logic [31:0] ptr [3];
    logic [31:0] addr;
    logic [31:0] dst_val;
    logic [31:0] old;
    logic [3:0]  r;
    logic [1:0]  f;
    logic        dst_wr;
    int          k;
    for (k = 0; k < 3; k++) begin
      r = reg_field(cmd, k);
      addr = base + {26'd0, r, 2'b00};
      ptr[k] = r == 4'd15 ? ip : shadow[addr[2 +: IDX_W]];
      exp_opnd[k] = ptr_field(cmd, k) ? shadow[ptr[k][2 +: IDX_W]] : ptr[k];
    end
    f = cmd[25:24];
    dst_wr = f != 2'b11 && cmd[11:8] != 4'd15;
    dst_val = f == 2'b01 ? res + 32'd1 : (f == 2'b10 ? res - 32'd1 : res);
    if (dst_wr) begin
      expect_write(base + {26'd0, cmd[11:8], 2'b00}, dst_val);
    end
    for (k = 0; k < 3; k++) begin
      r = reg_field(cmd, k);
      f = flag_field(cmd, k);
      if ((f == 2'b01 || f == 2'b10) && r != 4'd15) begin
        if (ptr_field(cmd, k)) old = ptr[k];
        else if (dst_wr && r == cmd[11:8]) old = dst_val;
        else old = exp_opnd[k];
        expect_write(base + {26'd0, r, 2'b00}, f == 2'b01 ? old + 32'd1 : old - 32'd1);
      end
    end
  endtask

  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else abort_run("awvalid dropped or awaddr changed before awready");
  a_w_hold: assert property (@(posedge clk) disable iff (rst)
    wvalid && !wready |=> wvalid && $stable(wdata))
    else abort_run("wvalid dropped or wdata changed before wready");
  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else abort_run("arvalid dropped or araddr changed before arready");
  a_wstrb: assert property (@(posedge clk) disable iff (rst)
    wvalid |-> wstrb == 4'hf)
    else flag_mismatch($sformatf("wstrb %h, expected f", wstrb));
  a_opnd_hold: assert property (@(posedge clk) disable iff (rst)
    opnd_valid && !res_valid |=> opnd_valid && $stable(cond_val) &&
                                 $stable(src1_val) && $stable(src0_val))
    else abort_run("operands changed while the result was still pending");
  a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else abort_run("done stayed high for more than one cycle");

  // outputs sampled mid cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (opnd_valid) begin
        assert (cond_val == exp_opnd[0])
          else flag_mismatch($sformatf("cond_val %h, expected %h", cond_val, exp_opnd[0]));
        assert (src1_val == exp_opnd[1])
          else flag_mismatch($sformatf("src1_val %h, expected %h", src1_val, exp_opnd[1]));
        assert (src0_val == exp_opnd[2])
          else flag_mismatch($sformatf("src0_val %h, expected %h", src0_val, exp_opnd[2]));
      end
      if (log_valid) begin
        assert (log_addr != cur_base + 32'd60)
          else abort_run("a write reached the instruction pointer slot");
        if (exp_addr_q.size() == 0) begin
          abort_run($sformatf("unexpected write of %h to %h", log_data, log_addr));
        end else begin
          assert (log_addr == exp_addr_q[0] && log_data == exp_data_q[0])
            else flag_mismatch($sformatf("write %h to %h, expected %h to %h",
                                         log_data, log_addr, exp_data_q[0], exp_addr_q[0]));
          void'(exp_addr_q.pop_front());
          void'(exp_data_q.pop_front());
        end
      end
      if (busy) begin
        assert (!cmd_ready) else abort_run("cmd_ready high while a command was in flight");
      end
      if (done) begin
        assert (busy) else abort_run("done pulsed with no command in flight");
        assert (exp_addr_q.size() == 0) else abort_run("command finished with writes missing");
        busy = 1'b0;
        done_count++;
      end
      if (cmd_valid && cmd_ready) begin
        busy = 1'b1;
      end
    end
  end

  initial begin
    logic [31:0] cmd;
    logic [31:0] base;
    logic [31:0] ip;
    logic [31:0] res;
    int          n;
    int          i;
    int          gap;
    rst        = 1'b1;
    cmd_valid  = 1'b0;
    cmd_word   = '0;
    base_addr  = '0;
    ip_value   = '0;
    res_valid  = 1'b0;
    res_data   = '0;
    busy       = 1'b0;
    done_count = 0;
    cur_base   = '0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    for (i = 0; i < WORDS; i++) begin
      shadow[i] = mem_i.mem[i];
    end
    for (n = 0; n < NUM_CMDS; n++) begin
      cmd = random_bits(32);
      // force some destination aliasing on src0
      if (random_bits(2) == 32'd0) cmd[7:4] = cmd[11:8];
      base = random_bits(6) << 2;
      ip = random_bits(IDX_W) << 2;
      res = random_bits(32);
      predict_command(cmd, base, ip, res);
      cur_base  = base;
      cmd_valid = 1'b1;
      cmd_word  = cmd;
      base_addr = base;
      ip_value  = ip;
      do @(negedge clk); while (!cmd_ready);
      @(posedge clk);
      #1;
      // command inputs only count on the accept cycle
      cmd_valid = 1'b0;
      cmd_word  = ~cmd;
      base_addr = ~base;
      ip_value  = ~ip;
      do @(negedge clk); while (!opnd_valid);
      gap = random_bits(2);
      @(posedge clk);
      repeat (gap) @(posedge clk);
      #1;
      res_valid = 1'b1;
      res_data  = res;
      do @(negedge clk); while (!res_ready);
      @(posedge clk);
      #1;
      // result only counts on the accept cycle
      res_valid = 1'b0;
      res_data  = ~res;
      do @(negedge clk); while (!done);
      @(posedge clk);
      #1;
    end
    if (done_count != NUM_CMDS || exp_addr_q.size() != 0) begin
      abort_run($sformatf("%0d done pulses for %0d commands", done_count, NUM_CMDS));
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

  // 200 cycles of 8 ns per command
  initial begin
    #(NUM_CMDS * 200 * 8);
    abort_run("timeout, the commands did not complete");
  end

endmodule

`default_nettype wire

//--- tb.f
verilog/operand_pkg.sv
verilog/axi_lite_master.sv
verilog/operand_fetch.sv
verilog/operand_writeback.sv
verilog/operand_sequencer.sv
verilog/operand_unit.sv
dv/axi_mem_model.sv
dv/tb_operand_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_operand_unit
FILELIST  := tb.f
BUILD     := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --timescale 1ns/1ps --top-module $(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
